//--- rtl/isa_pkg.sv
package isa_pkg;

    // rv32 base opcode map, bits [6:0] of every 32-bit instruction
    // low two bits are always 2'b11 for non-compressed encodings

    // integer register-register ops
    localparam logic [6:0] opc_op = 7'b0110011;
    // integer register-immediate ops
    localparam logic [6:0] opc_op_imm = 7'b0010011;
    // loads and stores
    localparam logic [6:0] opc_load = 7'b0000011;
    localparam logic [6:0] opc_store = 7'b0100011;
    // conditional branches
    localparam logic [6:0] opc_branch = 7'b1100011;
    // jumps, both write the link register
    localparam logic [6:0] opc_jal = 7'b1101111;
    localparam logic [6:0] opc_jalr = 7'b1100111;
    // upper immediate forms
    localparam logic [6:0] opc_lui = 7'b0110111;
    localparam logic [6:0] opc_auipc = 7'b0010111;
    // ecall, ebreak and csr access
    localparam logic [6:0] opc_system = 7'b1110011;

    // architectural register index, x0..x31
    typedef logic [4:0] reg_idx_t;

    // coarse class handed to dispatch
    // anything not listed above decodes to op_illegal
    typedef enum logic [3:0] {
        op_alu,
        op_alu_imm,
        op_load,
        op_store,
        op_branch,
        op_jal,
        op_jalr,
        op_lui,
        op_auipc,
        op_system,
        op_illegal
    } opclass_e;

endpackage

//--- rtl/fetch_pkg.sv
package fetch_pkg;

    // address and data width
    localparam int xlen = 32;

    // prefetch queue entries
    // must stay a power of two, pointers wrap by overflow
    localparam int queue_depth = 8;

    // one fetched instruction on its way into the queue
    typedef struct packed {
        // low means the rest is garbage
        logic valid;
        // word picked out of the 64-bit memory beat
        logic [31:0] inst;
        // address of inst
        logic [xlen-1:0] pc;
        // sequential successor, pc + 4
        logic [xlen-1:0] npc;
    } fetch_packet_t;

    // predecoded instruction held for dispatch
    typedef struct packed {
        logic valid;
        logic [xlen-1:0] pc;
        logic [xlen-1:0] npc;
        logic [31:0] inst;
        // coarse class from the major opcode
        isa_pkg::opclass_e op_class;
        // zero where the class has no such operand
        isa_pkg::reg_idx_t rd;
        isa_pkg::reg_idx_t rs1;
        isa_pkg::reg_idx_t rs2;
    } decoded_packet_t;

endpackage

//--- rtl/fetch_pc_gen.sv
module fetch_pc_gen (
    input logic clock,
    input logic reset,
    // memory answered this cycle
    input logic mem_ready,
    input logic [63:0] mem_data,
    // redirect from the back end, one-cycle strobe
    input logic take_branch,
    input logic [fetch_pkg::xlen-1:0] branch_target,
    // queue has no room
    input logic full,
    output logic [fetch_pkg::xlen-1:0] mem_addr,
    output logic fetch_valid,
    output fetch_pkg::fetch_packet_t fetch_packet
);

    // pc currently being fetched
    logic [fetch_pkg::xlen-1:0] pc;
    logic [fetch_pkg::xlen-1:0] pc_plus_4;
    logic [fetch_pkg::xlen-1:0] next_pc;
    logic pc_enable;
    logic [31:0] inst_word;

    // memory is doubleword wide, so drop the low three bits
    assign mem_addr = {pc[fetch_pkg::xlen-1:3], 3'b000};

    // pc bit 2 picks which half of the beat holds our word
    assign inst_word = pc[2] ? mem_data[63:32] : mem_data[31:0];

    assign pc_plus_4 = pc + fetch_pkg::xlen'(4);

    // accepted fetch: memory answered and the queue can take it
    // a redirect in the same cycle kills the fetch, its pc is stale
    assign fetch_valid = mem_ready && !full && !take_branch;

    // branch must win over a stall or the redirect is lost
    assign pc_enable = fetch_valid || take_branch;
    assign next_pc = take_branch ? branch_target : pc_plus_4;

    // packet into the queue
    always_comb begin
        fetch_packet.valid = fetch_valid;
        fetch_packet.inst = inst_word;
        fetch_packet.pc = pc;
        fetch_packet.npc = pc_plus_4;
    end

    // pc register, boots at address 0
    always_ff @(posedge clock) begin
        if (reset) begin
            pc <= '0;
        end else if (pc_enable) begin
            pc <= next_pc;
        end
    end

endmodule

//--- rtl/prefetch_queue.sv
module prefetch_queue (
    input logic clock,
    input logic reset,
    // redirect, drops every buffered packet
    input logic flush,
    input logic write,
    input fetch_pkg::fetch_packet_t write_packet,
    input logic pop,
    // oldest entry, valid only when not empty
    output fetch_pkg::fetch_packet_t head,
    output logic empty,
    output logic full
);

    // pointer wide enough to index every entry
    typedef logic [$clog2(fetch_pkg::queue_depth)-1:0] ptr_t;
    // count needs one more bit to reach queue_depth itself
    typedef logic [$clog2(fetch_pkg::queue_depth):0] count_t;

    // storage, no reset needed
    fetch_pkg::fetch_packet_t entries [fetch_pkg::queue_depth];

    ptr_t wr_ptr;
    ptr_t rd_ptr;
    count_t count;

    logic do_write;
    logic do_pop;

    assign empty = (count == '0);
    assign full = (count == count_t'(fetch_pkg::queue_depth));

    // qualify both sides
    // a flush wins, so a write in the flush cycle is dropped
    assign do_write = write && !full && !flush;
    assign do_pop = pop && !empty && !flush;

    // head is read straight out of the array
    // valid masked so stale or unwritten entries never leak out
    always_comb begin
        head = entries[rd_ptr];
        head.valid = entries[rd_ptr].valid && !empty;
    end

    // entry write
    always_ff @(posedge clock) begin
        if (do_write) begin
            entries[wr_ptr] <= write_packet;
        end
    end

    // pointers, pointers wrap naturally at a power-of-two depth
    always_ff @(posedge clock) begin
        if (reset || flush) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (do_write) begin
                wr_ptr <= wr_ptr + ptr_t'(1);
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + ptr_t'(1);
            end
        end
    end

    // occupancy
    // write and pop together leave it unchanged
    always_ff @(posedge clock) begin
        if (reset || flush) begin
            count <= '0;
        end else begin
            case ({do_write, do_pop})
                2'b10: begin
                    count <= count + count_t'(1);
                end
                2'b01: begin
                    count <= count - count_t'(1);
                end
                default: begin
                    count <= count;
                end
            endcase
        end
    end

endmodule

//--- rtl/inst_predecode.sv
module inst_predecode (
    input logic clock,
    input logic reset,
    // redirect, clears the held packet
    input logic flush,
    input fetch_pkg::fetch_packet_t head,
    input logic empty,
    // dispatch takes packet_out this cycle
    input logic dispatch_ready,
    output logic pop,
    output fetch_pkg::decoded_packet_t packet_out
);

    logic [6:0] opcode;
    isa_pkg::opclass_e op_class;
    // which register fields the class actually uses
    logic uses_rd;
    logic uses_rs1;
    logic uses_rs2;
    fetch_pkg::decoded_packet_t decoded;

    assign opcode = head.inst[6:0];

    // major opcode to class, plus operand usage
    always_comb begin
        op_class = isa_pkg::op_illegal;
        uses_rd = 1'b0;
        uses_rs1 = 1'b0;
        uses_rs2 = 1'b0;
        case (opcode)
            isa_pkg::opc_op: begin
                op_class = isa_pkg::op_alu;
                uses_rd = 1'b1;
                uses_rs1 = 1'b1;
                uses_rs2 = 1'b1;
            end
            isa_pkg::opc_op_imm: begin
                op_class = isa_pkg::op_alu_imm;
                uses_rd = 1'b1;
                uses_rs1 = 1'b1;
            end
            isa_pkg::opc_load: begin
                op_class = isa_pkg::op_load;
                uses_rd = 1'b1;
                uses_rs1 = 1'b1;
            end
            // stores and branches write no register
            isa_pkg::opc_store: begin
                op_class = isa_pkg::op_store;
                uses_rs1 = 1'b1;
                uses_rs2 = 1'b1;
            end
            isa_pkg::opc_branch: begin
                op_class = isa_pkg::op_branch;
                uses_rs1 = 1'b1;
                uses_rs2 = 1'b1;
            end
            isa_pkg::opc_jal: begin
                op_class = isa_pkg::op_jal;
                uses_rd = 1'b1;
            end
            isa_pkg::opc_jalr: begin
                op_class = isa_pkg::op_jalr;
                uses_rd = 1'b1;
                uses_rs1 = 1'b1;
            end
            isa_pkg::opc_lui: begin
                op_class = isa_pkg::op_lui;
                uses_rd = 1'b1;
            end
            isa_pkg::opc_auipc: begin
                op_class = isa_pkg::op_auipc;
                uses_rd = 1'b1;
            end
            // csr forms read rs1 and write rd, ecall fields are zero anyway
            isa_pkg::opc_system: begin
                op_class = isa_pkg::op_system;
                uses_rd = 1'b1;
                uses_rs1 = 1'b1;
            end
            default: begin
                op_class = isa_pkg::op_illegal;
            end
        endcase
    end

    // next packet, unused operand fields forced to x0
    always_comb begin
        decoded.valid = head.valid;
        decoded.pc = head.pc;
        decoded.npc = head.npc;
        decoded.inst = head.inst;
        decoded.op_class = op_class;
        decoded.rd = uses_rd ? head.inst[11:7] : '0;
        decoded.rs1 = uses_rs1 ? head.inst[19:15] : '0;
        decoded.rs2 = uses_rs2 ? head.inst[24:20] : '0;
    end

    // take the head when the slot is free or being drained
    assign pop = !empty && !flush && (!packet_out.valid || dispatch_ready);

    // output register
    // payload only moves on pop, valid drops once dispatch takes it
    always_ff @(posedge clock) begin
        if (pop) begin
            packet_out <= decoded;
        end
        if (reset || flush) begin
            packet_out.valid <= 1'b0;
        end else if (!pop && dispatch_ready) begin
            packet_out.valid <= 1'b0;
        end
    end

endmodule

//--- rtl/fetch_unit.sv
module fetch_unit (
    input logic clock,
    input logic reset,
    // instruction memory, answers in the same cycle
    input logic mem_ready,
    input logic [63:0] mem_data,
    output logic [fetch_pkg::xlen-1:0] mem_addr,
    // back end redirect
    input logic take_branch,
    input logic [fetch_pkg::xlen-1:0] branch_target,
    // dispatch side
    input logic dispatch_ready,
    output fetch_pkg::decoded_packet_t packet_out
);

    // pc gen to queue
    logic fetch_valid;
    fetch_pkg::fetch_packet_t fetch_packet;
    logic queue_full;

    // queue to predecode
    fetch_pkg::fetch_packet_t queue_head;
    logic queue_empty;
    logic queue_pop;

    // pc, memory address and word select
    fetch_pc_gen u_pc_gen (
        .clock(clock),
        .reset(reset),
        .mem_ready(mem_ready),
        .mem_data(mem_data),
        .take_branch(take_branch),
        .branch_target(branch_target),
        .full(queue_full),
        .mem_addr(mem_addr),
        .fetch_valid(fetch_valid),
        .fetch_packet(fetch_packet)
    );

    // decouples fetch from dispatch stalls
    // flushed by the same branch strobe
    prefetch_queue u_queue (
        .clock(clock),
        .reset(reset),
        .flush(take_branch),
        .write(fetch_valid),
        .write_packet(fetch_packet),
        .pop(queue_pop),
        .head(queue_head),
        .empty(queue_empty),
        .full(queue_full)
    );

    // class and register fields, one registered slot
    inst_predecode u_predecode (
        .clock(clock),
        .reset(reset),
        .flush(take_branch),
        .head(queue_head),
        .empty(queue_empty),
        .dispatch_ready(dispatch_ready),
        .pop(queue_pop),
        .packet_out(packet_out)
    );

endmodule

//--- testbench/fetch_unit_tb.sv
module fetch_unit_tb;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int reset_cycles = 8;
    localparam int cycles_per_record = 20;
    localparam string golden_path = "testbench/fetch_golden.txt";

    logic clock;
    logic reset;
    logic mem_ready;
    logic [63:0] mem_data;
    logic [fetch_pkg::xlen-1:0] mem_addr;
    logic take_branch;
    logic [fetch_pkg::xlen-1:0] branch_target;
    logic dispatch_ready;
    fetch_pkg::decoded_packet_t packet_out;

    // program image by doubleword address
    logic [63:0] image [logic [31:0]];
    // branch strobes keyed on accepted packet count
    int branch_at [$];
    logic [31:0] branch_to [$];
    // expected dispatch order
    logic [31:0] exp_pc [$];
    isa_pkg::opclass_e exp_class [$];
    isa_pkg::reg_idx_t exp_rd [$];
    isa_pkg::reg_idx_t exp_rs1 [$];
    isa_pkg::reg_idx_t exp_rs2 [$];

    logic [31:0] lfsr_state;
    int stall_left;
    int accepted;
    int branch_index;
    int check_count;
    int error_count;
    bit golden_loaded;
    bit hold_pending;
    fetch_pkg::decoded_packet_t held_packet;

    fetch_unit uut (
        .clock(clock),
        .reset(reset),
        .mem_ready(mem_ready),
        .mem_data(mem_data),
        .mem_addr(mem_addr),
        .take_branch(take_branch),
        .branch_target(branch_target),
        .dispatch_ready(dispatch_ready),
        .packet_out(packet_out)
    );

    initial begin
        clock = 1'b0;
        forever #5 clock = ~clock;
    end

    // unmapped addresses return a pattern of the whole address
    function automatic logic [63:0] image_word(input logic [31:0] addr);
        logic [63:0] beat;
        beat = {addr ^ 32'h5a5a_5a5a, ~addr};
        if (image.exists(addr)) begin
            beat = image[addr];
        end
        return beat;
    endfunction

    // word at pc, upper half when pc bit 2 is set
    function automatic logic [31:0] expected_inst(input logic [31:0] pc);
        logic [63:0] beat;
        beat = image_word({pc[31:3], 3'b000});
        return pc[2] ? beat[63:32] : beat[31:0];
    endfunction

    // memory answers in the same cycle
    always_comb begin
        if (golden_loaded) begin
            mem_data = image_word(mem_addr);
        end else begin
            mem_data = '0;
        end
    end

    // taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] state);
        logic feedback;
        feedback = state[31] ^ state[21] ^ state[1] ^ state[0];
        return {state[30:0], feedback};
    endfunction

    // one lfsr step per bit
    function automatic logic [4:0] random_bits(input int count);
        logic [4:0] bits;
        bits = '0;
        for (int i = 0; i < count; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            bits[i] = lfsr_state[0];
        end
        return bits;
    endfunction

    // mem_ready high 3 of 4 cycles
    // dispatch stalls now and then for 13 to 28 cycles to fill the queue
    task automatic drive_levels();
        logic [4:0] draw;
        draw = random_bits(2);
        mem_ready <= |draw[1:0];
        if (stall_left > 0) begin
            stall_left--;
            dispatch_ready <= 1'b0;
        end else begin
            draw = random_bits(5);
            if (draw == 5'd0) begin
                stall_left = 12 + int'(random_bits(4));
                dispatch_ready <= 1'b0;
            end else begin
                draw = random_bits(1);
                dispatch_ready <= draw[0];
            end
        end
    endtask

    task automatic report_error(input string msg);
        error_count++;
        $display("Error at %0d ns: %s", $time, msg);
    endtask

    task automatic check_packet(input int index);
        logic [31:0] want_pc;
        isa_pkg::opclass_e got_class;
        isa_pkg::opclass_e want_class;
        want_pc = exp_pc[index];
        got_class = packet_out.op_class;
        want_class = exp_class[index];
        check_count++;
        if (packet_out.pc != want_pc) begin
            report_error($sformatf("packet %0d pc %h, expected %h", index, packet_out.pc, want_pc));
        end
        if (packet_out.npc != want_pc + 32'd4) begin
            report_error($sformatf("packet %0d npc %h for pc %h", index, packet_out.npc, want_pc));
        end
        if (packet_out.inst != expected_inst(want_pc)) begin
            report_error($sformatf("packet %0d inst %h, expected %h", index, packet_out.inst,
                expected_inst(want_pc)));
        end
        if (got_class != want_class) begin
            report_error($sformatf("packet %0d class %s, expected %s", index, got_class.name(),
                want_class.name()));
        end
        if ({packet_out.rd, packet_out.rs1, packet_out.rs2} !=
            {exp_rd[index], exp_rs1[index], exp_rs2[index]}) begin
            report_error($sformatf("packet %0d regs %0d %0d %0d, expected %0d %0d %0d", index,
                packet_out.rd, packet_out.rs1, packet_out.rs2,
                exp_rd[index], exp_rs1[index], exp_rs2[index]));
        end
    endtask

    // class names in the file are the enum names
    function automatic bit class_from_name(input string name, output isa_pkg::opclass_e op_class);
        isa_pkg::opclass_e candidate;
        candidate = candidate.first();
        op_class = isa_pkg::op_illegal;
        for (int i = 0; i < candidate.num(); i++) begin
            if (candidate.name() == name) begin
                op_class = candidate;
                return 1'b1;
            end
            candidate = candidate.next();
        end
        return 1'b0;
    endfunction

    // m image, b branch, e expected, # comment
    task automatic load_golden(output bit ok);
        int fd;
        int code;
        string tag;
        string rest;
        string name;
        logic [31:0] addr;
        logic [63:0] data;
        int count;
        isa_pkg::opclass_e op_class;
        isa_pkg::reg_idx_t rd;
        isa_pkg::reg_idx_t rs1;
        isa_pkg::reg_idx_t rs2;
        ok = 1'b0;
        fd = $fopen(golden_path, "r");
        if (fd != 0) begin
            ok = 1'b1;
            while (ok && $fscanf(fd, "%s", tag) == 1) begin
                if (tag.substr(0, 0) == "#") begin
                    code = $fgets(rest, fd);
                end else if (tag == "m") begin
                    code = $fscanf(fd, "%h %h", addr, data);
                    image[addr] = data;
                    ok = (code == 2);
                end else if (tag == "b") begin
                    code = $fscanf(fd, "%d %h", count, addr);
                    branch_at.push_back(count);
                    branch_to.push_back(addr);
                    ok = (code == 2);
                end else if (tag == "e") begin
                    code = $fscanf(fd, "%h %s %d %d %d", addr, name, rd, rs1, rs2);
                    ok = (code == 5) && class_from_name(name, op_class);
                    exp_pc.push_back(addr);
                    exp_class.push_back(op_class);
                    exp_rd.push_back(rd);
                    exp_rs1.push_back(rs1);
                    exp_rs2.push_back(rs2);
                end else begin
                    ok = 1'b0;
                end
            end
            $fclose(fd);
        end
    endtask

    // watchdog, budget scales with the expected sequence
    initial begin
        wait (golden_loaded);
        repeat (reset_cycles + cycles_per_record * exp_pc.size()) @(posedge clock);
        $display("timeout with %0d of %0d packets dispatched", accepted, exp_pc.size());
        $display("TB FAILED");
        $finish;
    end

    initial begin
        bit loaded_ok;
        reset = 1'b1;
        mem_ready = 1'b0;
        take_branch = 1'b0;
        branch_target = '0;
        dispatch_ready = 1'b0;
        lfsr_state = 32'h7eaa;
        load_golden(loaded_ok);
        if (!loaded_ok) begin
            $display("could not read %s or it holds a bad record", golden_path);
            $display("TB FAILED");
            $finish;
        end else begin
            golden_loaded = 1'b1;
            repeat (reset_cycles) @(posedge clock);
            if (packet_out.valid !== 1'b0 || mem_addr !== 32'd0) begin
                report_error("packet_out valid or mem_addr not cleared by reset");
            end
            reset <= 1'b0;
            drive_levels();
            while (accepted < exp_pc.size()) begin
                @(posedge clock);
                // stalled output must not move
                if (hold_pending && packet_out != held_packet) begin
                    report_error("packet_out changed while dispatch_ready was low");
                end
                hold_pending = packet_out.valid && !dispatch_ready && !take_branch;
                held_packet = packet_out;
                // packet shown in the branch cycle is squashed
                if (packet_out.valid && dispatch_ready && !take_branch) begin
                    check_packet(accepted);
                    accepted++;
                end
                if (branch_index < branch_at.size() && accepted == branch_at[branch_index]) begin
                    take_branch <= 1'b1;
                    branch_target <= branch_to[branch_index];
                    branch_index++;
                end else begin
                    take_branch <= 1'b0;
                end
                drive_levels();
            end
            $display("%0d packets, %0d checks, %0d errors", accepted, check_count, error_count);
            if (error_count == 0) begin
                $display("TB PASSED");
            end else begin
                $display("TB FAILED");
            end
            $finish;
        end
    end

endmodule

//--- testbench/fetch_golden.txt
# m <doubleword address> <64-bit data with the word at address + 4 on top>
# b <accepted packet count> <branch target pc>
# e <pc> <op class> <rd> <rs1> <rs2> in dispatch order
m 00000000 fff30293003100b3
m 00000008 0095262300842383
m 00000010 008006ef00c58863
m 00000018 1234583700078767
m 00000020 3009997300001897
m 00000028 416a8a330023450b
m 00000030 000d4c83055c6b93
m 00000038 0000007301be00a3
m 00000100 0010813300100093
m 00000108 00012203fe311ce3
m 00000110 0000806700412223
m 00000118 ffffffffffffffb7
# straight run from reset
e 00000000 op_alu 1 2 3
e 00000004 op_alu_imm 5 6 0
e 00000008 op_load 7 8 0
e 0000000c op_store 0 10 9
e 00000010 op_branch 0 11 12
e 00000014 op_jal 13 0 0
e 00000018 op_jalr 14 15 0
e 0000001c op_lui 16 0 0
b 8 00000104
e 00000104 op_alu 2 1 1
e 00000108 op_branch 0 2 3
e 0000010c op_load 4 2 0
e 00000110 op_store 0 2 4
e 00000114 op_jalr 0 1 0
e 00000118 op_lui 31 0 0
e 0000011c op_illegal 0 0 0
b 15 00000020
e 00000020 op_auipc 17 0 0
e 00000024 op_system 18 19 0
e 00000028 op_illegal 0 0 0
e 0000002c op_alu 20 21 22
e 00000030 op_alu_imm 23 24 0
e 00000034 op_load 25 26 0
e 00000038 op_store 0 28 27
e 0000003c op_system 0 0 0
b 23 00000100
e 00000100 op_alu_imm 1 0 0
e 00000104 op_alu 2 1 1
e 00000108 op_branch 0 2 3
e 0000010c op_load 4 2 0

//--- fetch_unit.f
rtl/isa_pkg.sv
rtl/fetch_pkg.sv
rtl/fetch_pc_gen.sv
rtl/prefetch_queue.sv
rtl/inst_predecode.sv
rtl/fetch_unit.sv
testbench/fetch_unit_tb.sv

//--- Makefile
# override any of these on the command line
VERILATOR ?= verilator
TOP ?= fetch_unit_tb
FILELIST ?= fetch_unit.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing -j 0

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, search $(LOG) for the pass line"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o $(TOP)
	./$(BUILD_DIR)/$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@grep -q "^TB PASSED$$" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
